//--- project.f
+incdir+verilog
+incdir+verif
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/pipeLinks.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/armPipeTop.sv
verif/armPipeTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = armPipeTb
FILELIST  = project.f
PASS_MSG  = *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- verif/tbAsm.svh
`ifndef TB_ASM_SVH
`define TB_ASM_SVH

localparam logic [31:0] BUBBLE = 32'h0C00_0000;
localparam int          MAX_CYC = 1024;

// ISA-level model state and the bus activity it predicts per cycle.
logic [31:0] mReg [0:15];
logic [31:0] mMem [logic [31:0]];
logic        expWrite [0:MAX_CYC-1];
logic        expRead [0:MAX_CYC-1];
logic [31:0] expAddr [0:MAX_CYC-1];
logic [31:0] expData [0:MAX_CYC-1];

function automatic logic [31:0] encDpImm(logic [3:0] op, logic [3:0] rd, logic [3:0] rn,
                                         logic [11:0] imm);
   return {4'hE, 2'b00, 1'b1, op, 1'b0, rn, rd, imm};
endfunction

function automatic logic [31:0] encDpReg(logic [3:0] op, logic [3:0] rd, logic [3:0] rn,
                                         logic [3:0] rm, logic [4:0] sh);
   return {4'hE, 2'b00, 1'b0, op, 1'b0, rn, rd, sh, 3'b000, rm};
endfunction

function automatic logic [31:0] encMem(logic load, logic [3:0] rd, logic [3:0] rn,
                                       logic [11:0] off);
   return {4'hE, 2'b01, 1'b1, 4'b0000, load, rn, rd, off};
endfunction

// Unwritten memory reads back a value tied to its full address.
function automatic logic [31:0] fillWord(logic [31:0] addr);
   return {addr[15:0], addr[31:16]} ^ 32'h3C96_A5E1;
endfunction

function automatic logic [31:0] modelRead(logic [31:0] addr);
   return mMem.exists(addr) ? mMem[addr] : fillWord(addr);
endfunction

// Executes one instruction fetched in cycle idx.
task automatic modelStep(input logic [31:0] inst, input int idx);
   logic [3:0]  op;
   logic [3:0]  rn;
   logic [3:0]  rd;
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] addr;
   op = inst[24:21];
   rn = inst[19:16];
   rd = inst[15:12];
   b  = inst[25] ? {20'd0, inst[11:0]} : mReg[inst[3:0]] << inst[11:7];
   a  = (op == 4'b1101 || op == 4'b1111) ? 32'd0 : mReg[rn];
   if (inst[27:26] == 2'b00) begin
      case (op)
         4'b0000: mReg[rd] = a & b;
         4'b0001: mReg[rd] = a ^ b;
         4'b0010: mReg[rd] = a - b;
         4'b0100: mReg[rd] = a + b;
         4'b1100: mReg[rd] = a | b;
         4'b1101: mReg[rd] = b;
         4'b1110: mReg[rd] = a & ~b;
         4'b1111: mReg[rd] = ~b;
         default: ;
      endcase
   end else if (inst[27:26] == 2'b01) begin
      addr             = mReg[rn] + {20'd0, inst[11:0]};
      expAddr[idx + 3] = addr;
      if (inst[20]) begin
         expRead[idx + 3] = 1'b1;
         mReg[rd]         = modelRead(addr);
      end else begin
         expWrite[idx + 3] = 1'b1;
         expData[idx + 3]  = mReg[rd];
         mMem[addr]        = mReg[rd];
      end
   end
endtask

`endif

//--- verif/armPipeTb.sv
`timescale 1ns/1ps
`default_nettype none

module armPipeTb;

   `include "tbAsm.svh"

   logic        clk;
   logic        reset;
   logic [31:0] i_inst;
   logic [31:0] i_readData;
   logic [31:0] o_pc;
   logic        o_memRead;
   logic        o_memWrite;
   logic [31:0] o_memAddr;
   logic [31:0] o_writeData;

   logic [31:0] prog [$];
   logic [31:0] dMem [logic [31:0]];
   logic [3:0]  opList [0:7] = '{4'h0, 4'h1, 4'h2, 4'h4, 4'hC, 4'hD, 4'hE, 4'hF};
   integer      seed = 69469;
   int          errors = 0;
   int          cyc = 0;
   int          totalCyc = 0;
   int          cycLimit = MAX_CYC;

   armPipeTop u_dut (
      .clk         (clk),
      .reset       (reset),
      .i_inst      (i_inst),
      .i_readData  (i_readData),
      .o_pc        (o_pc),
      .o_memRead   (o_memRead),
      .o_memWrite  (o_memWrite),
      .o_memAddr   (o_memAddr),
      .o_writeData (o_writeData)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ******************************
   // Program and data memories.
   // ******************************
   always @(posedge clk) begin
      if (o_memWrite) begin
         dMem[o_memAddr] = o_writeData;
      end
      #1;
      i_inst     = ((o_pc >> 2) < prog.size()) ? prog[o_pc >> 2] : BUBBLE;
      i_readData = dMem.exists(o_memAddr) ? dMem[o_memAddr] : fillWord(o_memAddr);
   end

   always @(posedge clk) begin
      totalCyc <= totalCyc + 1;
      if (!reset) begin
         cyc <= cyc + 1;
      end
      if (totalCyc > cycLimit) begin
         $display("Timeout: pipeline did not drain after %0d cycles", totalCyc);
         $display("*** FAILED ***");
         $finish;
      end
   end

   // Each instruction is followed by two bubbles, so no producer is read too early.
   task automatic emit(input logic [31:0] inst);
      prog.push_back(inst);
      prog.push_back(BUBBLE);
      prog.push_back(BUBBLE);
   endtask

   task automatic emitRandom();
      logic [31:0] r;
      r = $random(seed);
      if (r[2:0] < 3'd5) begin
         if (r[3]) begin
            emit(encDpImm(opList[r[6:4]], r[10:7], r[14:11], r[26:15]));
         end else begin
            emit(encDpReg(opList[r[6:4]], r[10:7], r[14:11], r[18:15], r[23:19]));
         end
      end else begin
         emit(encMem(r[2:0] != 3'd7, r[10:7], r[14:11], r[26:15]));
      end
   endtask

   // ******************************
   // Checks.
   // ******************************
   a_resetQuiet: assert property (@(posedge clk) reset |-> !o_memRead && !o_memWrite)
      else begin
         errors++;
         $display("CHECK FAILED t=%0t o_memRead/o_memWrite got %b/%b exp 0/0", $time,
                  $sampled(o_memRead), $sampled(o_memWrite));
      end

   a_pcStep: assert property (@(posedge clk) disable iff (reset) o_pc == cyc * 4)
      else begin
         errors++;
         $display("CHECK FAILED t=%0t o_pc got %h exp %h", $time, $sampled(o_pc),
                  $sampled(cyc) * 4);
      end

   a_writeTime: assert property (@(posedge clk) disable iff (reset)
      o_memWrite == expWrite[cyc])
      else begin
         errors++;
         $display("CHECK FAILED t=%0t o_memWrite got %b exp %b", $time,
                  $sampled(o_memWrite), expWrite[$sampled(cyc)]);
      end

   a_readTime: assert property (@(posedge clk) disable iff (reset)
      o_memRead == expRead[cyc])
      else begin
         errors++;
         $display("CHECK FAILED t=%0t o_memRead got %b exp %b", $time,
                  $sampled(o_memRead), expRead[$sampled(cyc)]);
      end

   a_addr: assert property (@(posedge clk) disable iff (reset)
      (o_memWrite || o_memRead) |-> o_memAddr == expAddr[cyc])
      else begin
         errors++;
         $display("CHECK FAILED t=%0t o_memAddr got %h exp %h", $time,
                  $sampled(o_memAddr), expAddr[$sampled(cyc)]);
      end

   a_storeData: assert property (@(posedge clk) disable iff (reset)
      o_memWrite |-> o_writeData == expData[cyc])
      else begin
         errors++;
         $display("CHECK FAILED t=%0t o_writeData got %h exp %h", $time,
                  $sampled(o_writeData), expData[$sampled(cyc)]);
      end

   initial begin
      reset      = 1'b1;
      i_inst     = BUBBLE;
      i_readData = '0;
      for (int i = 0; i < MAX_CYC; i++) begin
         expWrite[i] = 1'b0;
         expRead[i]  = 1'b0;
         expAddr[i]  = '0;
         expData[i]  = '0;
      end
      foreach (mReg[i]) begin
         mReg[i] = '0;
      end
      dMem[32'h100] = 32'hCAFE_F00D;
      mMem[32'h100] = 32'hCAFE_F00D;

      // Leading store shows up early if the word held in reset gets decoded.
      emit(encMem(1'b0, 4'd0, 4'd0, 12'h200));
      // Immediate forms, each result stored.
      emit(encDpImm(4'hD, 4'd2, 4'd0, 12'h5A3));
      for (int k = 0; k < 8; k++) begin
         emit(encDpImm(opList[k], 4'd4, 4'd2, 12'(12'h3C5 + k)));
         emit(encMem(1'b0, 4'd4, 4'd0, 12'(k * 4)));
      end
      // Register forms with shifts.
      emit(encDpImm(4'hD, 4'd3, 4'd0, 12'h0F1));
      foreach (opList[k]) begin
         for (int s = 0; s < 3; s++) begin
            emit(encDpReg(opList[k], 4'd5, 4'd2, 4'd3, (s == 2) ? 5'd31 : 5'(s)));
            emit(encMem(1'b0, 4'd5, 4'd0, 12'(12'h40 + 4 * s)));
         end
      end
      // Load then store of the loaded register.
      emit(encMem(1'b1, 4'd6, 4'd0, 12'h100));
      emit(encMem(1'b0, 4'd6, 4'd0, 12'h104));
      for (int k = 0; k < 40; k++) begin
         emitRandom();
      end

      foreach (prog[i]) begin
         modelStep(prog[i], i);
      end
      cycLimit = 2 * (10 + prog.size() + 5);

      repeat (10) @(posedge clk);
      #1 reset = 1'b0;
      while (cyc < prog.size() + 5) begin
         @(posedge clk);
      end
      #1;
      $display("Run complete: %0d errors", errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/armPipeTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "coreParams_params.svh"

module armPipeTop (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [`CORE_WORD_W-1:0] i_inst,
   input  logic [`CORE_WORD_W-1:0] i_readData,
   output logic [`CORE_WORD_W-1:0] o_pc,
   output logic                    o_memRead,
   output logic                    o_memWrite,
   output logic [`CORE_WORD_W-1:0] o_memAddr,
   output logic [`CORE_WORD_W-1:0] o_writeData
);

   logic [`CORE_WORD_W-1:0] instD;
   logic                    validD;

   // Stage links.
   decExecIf deLink ();
   execMemIf emLink ();
   wbIf      wbLink ();

   // ******************************
   // Pipeline stages.
   // ******************************
   fetchStage u_fetch (
      .clk      (clk),
      .reset    (reset),
      .i_inst   (i_inst),
      .o_pc     (o_pc),
      .o_instD  (instD),
      .o_validD (validD)
   );

   decodeStage u_decode (
      .clk      (clk),
      .reset    (reset),
      .i_instD  (instD),
      .i_validD (validD),
      .wb       (wbLink.dst),
      .ex       (deLink.src)
   );

   executeStage u_execute (
      .clk   (clk),
      .reset (reset),
      .ex    (deLink.dst),
      .mem   (emLink.src)
   );

   memoryStage u_memory (
      .clk         (clk),
      .reset       (reset),
      .mem         (emLink.dst),
      .i_readData  (i_readData),
      .o_memRead   (o_memRead),
      .o_memWrite  (o_memWrite),
      .o_memAddr   (o_memAddr),
      .o_writeData (o_writeData),
      .wb          (wbLink.src)
   );

endmodule

`default_nettype wire

//--- verilog/memoryStage.sv
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
   input  logic          clk,
   input  logic          reset,
   execMemIf.dst         mem,
   input  isaPkg::word_t i_readData,
   output logic          o_memRead,
   output logic          o_memWrite,
   output isaPkg::word_t o_memAddr,
   output isaPkg::word_t o_writeData,
   wbIf.src              wb
);
   import pipePkg::*;

   memWb_t mwNext;
   memWb_t mwReg;

   // Data memory request, straight from the EX/MEM register.
   assign o_memRead   = mem.pay.valid && mem.pay.memRead;
   assign o_memWrite  = mem.pay.valid && mem.pay.memWrite;
   assign o_memAddr   = mem.pay.result;
   assign o_writeData = mem.pay.storeData;

   always_comb begin
      mwNext.valid    = mem.pay.valid;
      mwNext.result   = o_memRead ? i_readData : mem.pay.result;
      mwNext.dest     = mem.pay.dest;
      mwNext.regWrite = mem.pay.regWrite;
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         mwReg <= '0;
      end else begin
         mwReg <= mwNext;
      end
   end

   assign wb.valid    = mwReg.valid;
   assign wb.regWrite = mwReg.regWrite;
   assign wb.dest     = mwReg.dest;
   assign wb.result   = mwReg.result;

   // ******************************
   // Checks.
   // ******************************
   a_strobesExclusive: assert property (@(posedge clk) disable iff (reset)
      !(o_memRead && o_memWrite));

endmodule

`default_nettype wire

//--- verilog/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
   input  logic  clk,
   input  logic  reset,
   decExecIf.dst ex,
   execMemIf.src mem
);
   import isaPkg::*;
   import pipePkg::*;

   word_t    shiftedB;
   word_t    aluResult;
   execMem_t emNext;
   execMem_t emReg;

   // Shift amount is zero for immediate and memory forms.
   assign shiftedB = ex.opB << ex.shamt;

   // ******************************
   // ALU.
   // ******************************
   always_comb begin
      case (ex.aluOp)
         OP_AND:  aluResult = ex.opA & shiftedB;
         OP_EOR:  aluResult = ex.opA ^ shiftedB;
         OP_SUB:  aluResult = ex.opA - shiftedB;
         OP_ADD:  aluResult = ex.opA + shiftedB;
         OP_ORR:  aluResult = ex.opA | shiftedB;
         OP_MOV:  aluResult = shiftedB;
         OP_BIC:  aluResult = ex.opA & ~shiftedB;
         OP_MVN:  aluResult = ~shiftedB;
         default: aluResult = '0;
      endcase
   end

   // Loads and stores arrive as ADD, so the result is the address.
   always_comb begin
      emNext.valid     = ex.valid;
      emNext.result    = aluResult;
      emNext.storeData = ex.storeData;
      emNext.dest      = ex.dest;
      emNext.regWrite  = ex.regWrite;
      emNext.memRead   = ex.memRead;
      emNext.memWrite  = ex.memWrite;
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         emReg <= '0;
      end else begin
         emReg <= emNext;
      end
   end

   assign mem.pay = emReg;

   a_opDefined: assert property (@(posedge clk) disable iff (reset)
      ex.valid |-> ex.aluOp inside {OP_AND, OP_EOR, OP_SUB, OP_ADD,
                                    OP_ORR, OP_MOV, OP_BIC, OP_MVN});

endmodule

`default_nettype wire

//--- verilog/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "coreParams_params.svh"

module decodeStage (
   input  logic          clk,
   input  logic          reset,
   input  isaPkg::word_t i_instD,
   input  logic          i_validD,
   wbIf.dst              wb,
   decExecIf.src         ex
);
   import isaPkg::*;
   import pipePkg::*;

   word_t      regFile [0:`CORE_REG_CNT-1];
   instClass_e instClass;
   aluOp_e     opcode;
   logic       immSel;
   logic       isLoad;
   logic       opValid;
   logic       isDp;
   logic       isMem;
   logic       wbWrite;
   regIdx_t    rn;
   regIdx_t    rd;
   regIdx_t    rm;
   shamt_t     shamt;
   word_t      imm32;
   word_t      rnData;
   word_t      rmData;
   word_t      rdData;
   decExec_t   deNext;
   decExec_t   deReg;

   // ******************************
   // Field extraction.
   // ******************************
   assign instClass = instClass_e'(i_instD[`CORE_CLS_LSB +: $bits(instClass_e)]);
   assign opcode    = aluOp_e'(i_instD[`CORE_OP_LSB +: $bits(aluOp_e)]);
   assign immSel    = i_instD[`CORE_IBIT];
   assign isLoad    = i_instD[`CORE_LBIT];
   assign rn        = i_instD[`CORE_RN_LSB +: `CORE_REG_IDX_W];
   assign rd        = i_instD[`CORE_RD_LSB +: `CORE_REG_IDX_W];
   assign rm        = i_instD[`CORE_RM_LSB +: `CORE_REG_IDX_W];
   assign shamt     = i_instD[`CORE_SHAMT_LSB +: `CORE_SHAMT_W];
   assign imm32     = {{(`CORE_WORD_W-`CORE_IMM_W){1'b0}}, i_instD[`CORE_IMM_W-1:0]};

   always_comb begin
      case (opcode)
         OP_AND, OP_EOR, OP_SUB, OP_ADD,
         OP_ORR, OP_MOV, OP_BIC, OP_MVN: opValid = 1'b1;
         default:                        opValid = 1'b0;
      endcase
   end

   // Reserved classes and undefined opcodes fall through as bubbles.
   assign isDp  = i_validD && (instClass == CLS_DP) && opValid;
   assign isMem = i_validD && (instClass == CLS_MEM);

   // ******************************
   // Register file with bypass.
   // ******************************
   assign wbWrite = wb.valid && wb.regWrite;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         foreach (regFile[i]) begin
            regFile[i] <= '0;
         end
      end else if (wbWrite) begin
         regFile[wb.dest] <= wb.result;
      end
   end

   // Same-cycle writeback wins over the stored value.
   assign rnData = (wbWrite && (wb.dest == rn)) ? wb.result : regFile[rn];
   assign rmData = (wbWrite && (wb.dest == rm)) ? wb.result : regFile[rm];
   assign rdData = (wbWrite && (wb.dest == rd)) ? wb.result : regFile[rd];

   // Operand selection.
   always_comb begin
      deNext           = '0;
      deNext.valid     = isDp || isMem;
      deNext.dest      = rd;
      deNext.storeData = rdData;
      if (isMem) begin
         // Address is Rn plus the unshifted offset.
         deNext.aluOp    = OP_ADD;
         deNext.opA      = rnData;
         deNext.opB      = imm32;
         deNext.regWrite = isLoad;
         deNext.memRead  = isLoad;
         deNext.memWrite = !isLoad;
      end else if (isDp) begin
         deNext.aluOp    = opcode;
         deNext.opA      = (opcode == OP_MOV || opcode == OP_MVN) ? '0 : rnData;
         deNext.opB      = immSel ? imm32 : rmData;
         deNext.shamt    = immSel ? '0 : shamt;
         deNext.regWrite = 1'b1;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         deReg <= '0;
      end else begin
         deReg <= deNext;
      end
   end

   assign ex.valid     = deReg.valid;
   assign ex.aluOp     = deReg.aluOp;
   assign ex.opA       = deReg.opA;
   assign ex.opB       = deReg.opB;
   assign ex.shamt     = deReg.shamt;
   assign ex.storeData = deReg.storeData;
   assign ex.dest      = deReg.dest;
   assign ex.regWrite  = deReg.regWrite;
   assign ex.memRead   = deReg.memRead;
   assign ex.memWrite  = deReg.memWrite;

   a_noReadAndWrite: assert property (@(posedge clk) disable iff (reset)
      ex.valid |-> !(ex.memRead && ex.memWrite));

endmodule

`default_nettype wire

//--- verilog/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "coreParams_params.svh"

module fetchStage (
   input  logic          clk,
   input  logic          reset,
   input  isaPkg::word_t i_inst,
   output isaPkg::word_t o_pc,
   output isaPkg::word_t o_instD,
   output logic          o_validD
);
   import isaPkg::*;

   word_t pcNext;

   // No branches, so the PC only steps.
   assign pcNext = o_pc + `CORE_PC_STEP;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         o_pc     <= '0;
         o_validD <= 1'b0;
      end else begin
         o_pc     <= pcNext;
         o_validD <= 1'b1;
      end
   end

   // Instruction word is qualified by o_validD.
   always_ff @(posedge clk) begin
      o_instD <= i_inst;
   end

endmodule

`default_nettype wire

//--- verilog/pipeLinks.sv
`timescale 1ns/1ps
`default_nettype none

// ******************************
// Decode to execute.
// ******************************
interface decExecIf;
   import isaPkg::*;

   logic    valid;
   aluOp_e  aluOp;
   word_t   opA;
   word_t   opB;
   shamt_t  shamt;
   word_t   storeData;
   regIdx_t dest;
   logic    regWrite;
   logic    memRead;
   logic    memWrite;

   modport src (output valid, aluOp, opA, opB, shamt, storeData, dest,
                regWrite, memRead, memWrite);
   modport dst (input valid, aluOp, opA, opB, shamt, storeData, dest,
                regWrite, memRead, memWrite);
endinterface

// ******************************
// Execute to memory.
// ******************************
interface execMemIf;
   import pipePkg::*;

   execMem_t pay;

   modport src (output pay);
   modport dst (input pay);
endinterface

// Writeback into the register file.
interface wbIf;
   import isaPkg::*;

   logic    valid;
   logic    regWrite;
   regIdx_t dest;
   word_t   result;

   modport src (output valid, regWrite, dest, result);
   modport dst (input valid, regWrite, dest, result);
endinterface

`default_nettype wire

//--- verilog/pipePkg.sv
`default_nettype none

package pipePkg;

   import isaPkg::*;

   // Decode to execute. Operand B is already selected.
   typedef struct packed {
      logic    valid;
      aluOp_e  aluOp;
      word_t   opA;
      word_t   opB;
      shamt_t  shamt;
      word_t   storeData;
      regIdx_t dest;
      logic    regWrite;
      logic    memRead;
      logic    memWrite;
   } decExec_t;

   // Execute to memory. Result doubles as the data address.
   typedef struct packed {
      logic    valid;
      word_t   result;
      word_t   storeData;
      regIdx_t dest;
      logic    regWrite;
      logic    memRead;
      logic    memWrite;
   } execMem_t;

   // Memory to writeback.
   typedef struct packed {
      logic    valid;
      word_t   result;
      regIdx_t dest;
      logic    regWrite;
   } memWb_t;

endpackage

`default_nettype wire

//--- verilog/isaPkg.sv
`default_nettype none

`include "coreParams_params.svh"

package isaPkg;

   typedef logic [`CORE_WORD_W-1:0]    word_t;
   typedef logic [`CORE_REG_IDX_W-1:0] regIdx_t;
   typedef logic [`CORE_SHAMT_W-1:0]   shamt_t;

   // Instruction class, bits 27:26.
   typedef enum logic [1:0] {
      CLS_DP   = 2'b00,
      CLS_MEM  = 2'b01,
      CLS_RSV2 = 2'b10,
      CLS_RSV3 = 2'b11
   } instClass_e;

   // ******************************
   // Data-processing opcodes.
   // ******************************
   typedef enum logic [3:0] {
      OP_AND = 4'b0000,
      OP_EOR = 4'b0001,
      OP_SUB = 4'b0010,
      OP_ADD = 4'b0100,
      OP_ORR = 4'b1100,
      OP_MOV = 4'b1101,
      OP_BIC = 4'b1110,
      OP_MVN = 4'b1111
   } aluOp_e;

endpackage

`default_nettype wire

//--- verilog/coreParams_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath sizes.
`define CORE_WORD_W     32
`define CORE_REG_CNT    16
`define CORE_REG_IDX_W  4
`define CORE_SHAMT_W    5
`define CORE_IMM_W      12
`define CORE_PC_STEP    4

// ******************************
// Instruction field positions.
// ******************************
`define CORE_CLS_LSB    26
`define CORE_IBIT       25
`define CORE_OP_LSB     21
`define CORE_LBIT       20
`define CORE_RN_LSB     16
`define CORE_RD_LSB     12
`define CORE_SHAMT_LSB  7
`define CORE_RM_LSB     0

`endif
